// ==== logic/az_consts.svh ====
// width, mux code, break length and minimum phase macros for the auto-zero modulator
`ifndef AZ_CONSTS_SVH
`define AZ_CONSTS_SVH

// phase duration in clock cycles
`define AZ_DUR_W 24

// input mux select, one of eight analog sources
`define AZ_MUX_W 3

// s1 is the precharge output (PC-OUT)
`define AZ_MUX_PC_OUT 0

// s8 is the 4.7k to star ground
`define AZ_MUX_ZERO 7

// cycles the mux stays disabled before a new selection
`define AZ_BREAK_CYCLES 2

// shortest phase accepted, kept above the break length
`define AZ_MIN_DUR 4

// monitor vector and its cycle count field
`define AZ_MON_W 7
`define AZ_CYC_W 5

`endif

// ==== logic/az_pkg.sv ====
// phase and state enums plus vector typedefs for the auto-zero modulator
`include "az_consts.svh"

package az_pkg;

  // one phase duration, counted in clocks
  typedef logic [`AZ_DUR_W-1:0] dur_t;

  // analog mux select code
  typedef logic [`AZ_MUX_W-1:0] mux_sel_t;

  // completed auto-zero cycles, wraps
  typedef logic [`AZ_CYC_W-1:0] cyc_cnt_t;

  // {cycle count, zero phase, signal phase}
  typedef logic [`AZ_MON_W-1:0] mon_vec_t;

  // which analog phase the front end is in
  typedef enum logic [1:0] {
    phase_none   = 2'd0,  // only seen straight after reset
    phase_signal = 2'd1,  // precharge switch closed, mux on PC-OUT
    phase_zero   = 2'd2   // switch open, mux on star ground
  } az_phase_e;

  // sequencer states, each phase has a one-cycle start and a hold
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_sig_start  = 3'd1,
    st_sig_hold   = 3'd2,
    st_zero_start = 3'd3,
    st_zero_hold  = 3'd4
  } az_state_e;

endpackage

// ==== logic/az_ctrl_if.sv ====
// interface between sequencer, phase timer and switch driver, with modports
`timescale 1ns/1ps

interface az_ctrl_if
  import az_pkg::*;
();

  logic      load;         // pulse, start counting a new phase
  dur_t      load_value;   // clamped duration for that phase
  logic      expired;      // timer has reached zero
  az_phase_e phase;        // current phase from the sequencer register
  logic      phase_start;  // pulse, a new phase begins

  // sequencer owns the phase and the timer load
  modport seq_mp (
    output load,
    output load_value,
    output phase,
    output phase_start,
    input  expired
  );

  // count-down timer
  modport timer_mp (
    input  load,
    input  load_value,
    output expired
  );

  // switch and mux output stage only follows the phase
  modport drv_mp (
    input phase,
    input phase_start
  );

endinterface

// ==== logic/phase_timer.sv ====
// phase_timer: loadable count-down timer with an expiry flag
`timescale 1ns/1ps

module phase_timer
  import az_pkg::*;
(
  input logic       clk,
  input logic       reset,  // async, active high
  az_ctrl_if.timer_mp ctrl
);

  dur_t count;  // cycles left in the current phase

  // counting down lets the end test be a simple compare to zero
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (ctrl.load)
    begin
      count <= ctrl.load_value;  // new phase length
    end
    else if (count != '0)
    begin
      count <= count - 1'b1;  // sticks at zero until reloaded
    end
  end

  // a pending load hides the old zero so the hold state never sees a stale expiry
  assign ctrl.expired = (count == '0) && !ctrl.load;

endmodule

// ==== logic/az_sequencer.sv ====
// az_sequencer: signal and zero phase FSM, cycle counter and monitor vector
`timescale 1ns/1ps
`include "az_consts.svh"

module az_sequencer
  import az_pkg::*;
(
  input  logic     clk,
  input  logic     reset,        // async, active high
  input  dur_t     reset_dur,    // signal phase length
  input  dur_t     settle_dur,   // zero phase length
  az_ctrl_if.seq_mp ctrl,
  output mon_vec_t vec_monitor
);

  az_state_e state;
  az_state_e state_nxt;
  az_phase_e phase_q;    // phase in force, also feeds the driver
  az_phase_e phase_nxt;
  cyc_cnt_t  cyc_cnt;    // completed signal+zero cycles
  cyc_cnt_t  cyc_nxt;
  dur_t      dur_nxt;    // duration sampled in a start state
  logic      in_start;   // one-cycle start state of either phase

  // raise short durations to the floor, the break must fit inside a phase
  function automatic dur_t clamp_dur(input dur_t d);
    dur_t floor_d;
    floor_d = dur_t'(`AZ_MIN_DUR);
    return (d < floor_d) ? floor_d : d;
  endfunction

  // everything a start state sets up, shared so both phases are built the same way
  function automatic void start_phase(
    input  az_phase_e ph,
    input  dur_t      sig_d,
    input  dur_t      zero_d,
    output az_state_e nxt,
    output az_phase_e ph_out,
    output dur_t      dur
  );
    ph_out = ph;
    if (ph == phase_signal)
    begin
      nxt = st_sig_hold;
      dur = clamp_dur(sig_d);
    end
    else
    begin
      nxt = st_zero_hold;
      dur = clamp_dur(zero_d);
    end
  endfunction

  always_comb
  begin
    state_nxt = state;
    phase_nxt = phase_q;
    cyc_nxt   = cyc_cnt;
    dur_nxt   = '0;  // only meaningful with load
    case (state)
      st_idle:
        state_nxt = st_sig_start;  // one cycle after reset, then run
      st_sig_start:
        start_phase(phase_signal, reset_dur, settle_dur, state_nxt, phase_nxt, dur_nxt);
      st_sig_hold:
        if (ctrl.expired)
          state_nxt = st_zero_start;
      st_zero_start:
        start_phase(phase_zero, reset_dur, settle_dur, state_nxt, phase_nxt, dur_nxt);
      st_zero_hold:
        if (ctrl.expired)
        begin
          state_nxt = st_sig_start;
          cyc_nxt   = cyc_cnt + 1'b1;  // a full auto-zero cycle is done, wraps
        end
      default:
        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state   <= st_idle;
      phase_q <= phase_none;
      cyc_cnt <= '0;
    end
    else
    begin
      state   <= state_nxt;
      phase_q <= phase_nxt;
      cyc_cnt <= cyc_nxt;
    end
  end

  assign in_start = (state == st_sig_start) || (state == st_zero_start);

  // load and phase_start are the same pulse, the timer and driver both key off it
  assign ctrl.load        = in_start;
  assign ctrl.phase_start = in_start;
  assign ctrl.load_value  = dur_nxt;
  assign ctrl.phase       = phase_q;

  // bit 0 signal, bit 1 zero, count above
  assign vec_monitor = {cyc_cnt, phase_q == phase_zero, phase_q == phase_signal};

endmodule

// ==== logic/switch_driver.sv ====
// switch_driver: precharge switch and input mux outputs with break-before-make
`timescale 1ns/1ps
`include "az_consts.svh"

module switch_driver
  import az_pkg::*;
(
  input  logic     clk,
  input  logic     reset,          // async, active high
  az_ctrl_if.drv_mp ctrl,
  output logic     sig_pc_sw_ctl,  // 1 closes the precharge switch
  output mux_sel_t mux_az,         // analog mux select
  output logic     mux_en          // mux enable, low during the break
);

  localparam int BRK_W = $clog2(`AZ_BREAK_CYCLES + 1);

  logic [BRK_W-1:0] brk_cnt;  // break cycles still to run, 0 when idle

  // switch state for a phase, anything but signal leaves it open
  function automatic logic sw_for(input az_phase_e ph);
    return (ph == phase_signal);
  endfunction

  // mux code for a phase
  function automatic mux_sel_t mux_for(input az_phase_e ph);
    if (ph == phase_signal)
      return mux_sel_t'(`AZ_MUX_PC_OUT);
    return mux_sel_t'(`AZ_MUX_ZERO);
  endfunction

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sig_pc_sw_ctl <= 1'b0;
      mux_az        <= mux_sel_t'(`AZ_MUX_ZERO);  // park on star ground
      mux_en        <= 1'b0;
      brk_cnt       <= '0;
    end
    else if (ctrl.phase_start)
    begin
      mux_en  <= 1'b0;  // break first
      brk_cnt <= BRK_W'(`AZ_BREAK_CYCLES);
    end
    else if (brk_cnt != '0)
    begin
      brk_cnt <= brk_cnt - 1'b1;
      if (brk_cnt == BRK_W'(1))
      begin
        // last break cycle, phase register has the new value by now
        sig_pc_sw_ctl <= sw_for(ctrl.phase);
        mux_az        <= mux_for(ctrl.phase);
        mux_en        <= 1'b1;  // make
      end
    end
  end

endmodule

// ==== logic/az_modulator.sv ====
// az_modulator: top level joining sequencer, phase timer and switch driver
`timescale 1ns/1ps

module az_modulator
  import az_pkg::*;
(
  input  logic     clk,
  input  logic     reset,          // async, active high
  input  dur_t     reset_dur,      // signal phase length in clocks
  input  dur_t     settle_dur,     // zero phase length in clocks
  output logic     sig_pc_sw_ctl,  // precharge switch
  output mux_sel_t mux_az,         // input mux select
  output logic     mux_en,         // input mux enable
  output mon_vec_t vec_monitor     // {cycle count, zero, signal}
);

  // control bundle between the three blocks
  az_ctrl_if ctrl_if ();

  // phase FSM, owns the timer load and the monitor
  az_sequencer az_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .reset_dur   (reset_dur),
    .settle_dur  (settle_dur),
    .ctrl        (ctrl_if.seq_mp),
    .vec_monitor (vec_monitor)
  );

  // counts each phase down
  phase_timer phase_timer_i (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl_if.timer_mp)
  );

  // analog side outputs
  switch_driver switch_driver_i (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (ctrl_if.drv_mp),
    .sig_pc_sw_ctl (sig_pc_sw_ctl),
    .mux_az        (mux_az),
    .mux_en        (mux_en)
  );

endmodule

// ==== verification/tb_clock.sv ====
// tb_clock: testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,  // clock period
  parameter int RESET_CYCLES = 10   // rising edges with reset held high
) (
  output logic clk,
  output logic reset  // active high
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset starts high and drops on a rising edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== verification/az_modulator_tb.sv ====
// directed tests, check task, timeout and summary for the auto-zero modulator
`timescale 1ns/1ps
`include "az_consts.svh"

module az_modulator_tb
  import az_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int MAX_DUR      = 15;   // largest duration any test applies
  localparam int TEST_PHASES  = 93;   // phases summed over all tests
  localparam int CYCLE_LIMIT  = 2 * TEST_PHASES * (MAX_DUR + 2) + RESET_CYCLES;
  localparam int CYC_MOD      = 1 << `AZ_CYC_W;  // cycle field wraps here

  logic     clk;
  logic     reset;
  dur_t     reset_dur;
  dur_t     settle_dur;
  logic     sig_pc_sw_ctl;
  mux_sel_t mux_az;
  logic     mux_en;
  mon_vec_t vec_monitor;

  int errors;
  int checks;
  int sw_rises;   // rises of sig_pc_sw_ctl since reset
  int seed;
  int cycle_cnt;  // timeout counter

  tb_clock #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (RESET_CYCLES)
  ) tb_clock_i (
    .clk   (clk),
    .reset (reset)
  );

  az_modulator az_modulator_i (
    .clk           (clk),
    .reset         (reset),
    .reset_dur     (reset_dur),
    .settle_dur    (settle_dur),
    .sig_pc_sw_ctl (sig_pc_sw_ctl),
    .mux_az        (mux_az),
    .mux_en        (mux_en),
    .vec_monitor   (vec_monitor)
  );

  // compare and log a mismatch
  task automatic check_val(input string msg, input int expected, input int actual);
    checks++;
    if (expected != actual)
    begin
      $display("[ERROR] %0t ns: %s, expected %0d, got %0d", $time, msg, expected, actual);
      errors++;
    end
  endtask

  // one line per finished test
  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before)
      $display("%-24s ok", name);
    else
      $display("%-24s failed with %0d errors", name, errors - errors_before);
  endtask

  // expected cycles of a phase for a requested duration
  function automatic int phase_len(input int d);
    return ((d < `AZ_MIN_DUR) ? `AZ_MIN_DUR : d) + 2;
  endfunction

  // new durations on the next rising edge
  task automatic set_durations(input int sig_d, input int zero_d);
    @(posedge clk);
    reset_dur  <= dur_t'(sig_d);
    settle_dur <= dur_t'(zero_d);
  endtask

  task automatic check_reset_values();
    check_val("sig_pc_sw_ctl at reset", 0, int'(sig_pc_sw_ctl));
    check_val("mux_en at reset", 0, int'(mux_en));
    check_val("mux_az at reset", `AZ_MUX_ZERO, int'(mux_az));
    check_val("vec_monitor at reset", 0, int'(vec_monitor));
  endtask

  // waits for the next switch change with samples at falling edges
  // cycles counts samples up to the change
  // low_run counts mux_en low samples just before it
  task automatic wait_sw_change(output int cycles, output int low_run);
    logic old_sw;
    logic changed;
    int   exp_mux;
    old_sw  = sig_pc_sw_ctl;
    cycles  = 0;
    low_run = 0;
    changed = 1'b0;
    while (!changed)
    begin
      @(negedge clk);
      cycles++;
      exp_mux = sig_pc_sw_ctl ? `AZ_MUX_PC_OUT : `AZ_MUX_ZERO;
      if (mux_en)
        check_val("mux_az matches switch while enabled", exp_mux, int'(mux_az));
      check_val("monitor phase bits both high", 0, int'(vec_monitor[0] & vec_monitor[1]));
      if (sig_pc_sw_ctl != old_sw)
      begin
        changed = 1'b1;
        check_val("mux_en high at switch change", 1, int'(mux_en));
        if (sig_pc_sw_ctl)
          sw_rises++;
      end
      else if (mux_en)
        low_run = 0;
      else
        low_run++;
    end
  endtask

  // outputs during reset and one cycle after release
  task automatic test_reset();
    int err0;
    err0 = errors;
    @(negedge clk);
    while (reset)
    begin
      check_reset_values();
      @(negedge clk);
    end
    check_reset_values();  // first cycle out of reset
    report_test("reset values", err0);
  endtask

  // signal 6 and zero 9 give 8 and 11 cycles
  task automatic test_phase_lengths();
    int err0;
    int n;
    int low;
    int i;
    err0 = errors;
    wait_sw_change(n, low);  // first close after reset
    // idle cycle and start cycle, then the break
    check_val("cycles from reset to first close", 2 + `AZ_BREAK_CYCLES, n);
    for (i = 0; i < 3; i++)
    begin
      wait_sw_change(n, low);
      check_val("signal phase length", 8, n);
      wait_sw_change(n, low);
      check_val("zero phase length", 11, n);
    end
    report_test("phase lengths", err0);
  endtask

  task automatic test_break_before_make();
    int err0;
    int n;
    int low;
    int i;
    err0 = errors;
    for (i = 0; i < 4; i++)
    begin
      wait_sw_change(n, low);
      check_val("mux_en low cycles before change", `AZ_BREAK_CYCLES, low);
    end
    report_test("break before make", err0);
  endtask

  // phase flags and the cycle field over a run past the wrap
  task automatic test_monitor();
    int err0;
    int n;
    int low;
    int i;
    err0 = errors;
    set_durations(4, 4);  // short phases since only the count matters
    for (i = 0; i < 34; i++)
    begin
      wait_sw_change(n, low);  // opens for the zero phase
      check_val("zero flag in zero phase", 1, int'(vec_monitor[1]));
      check_val("signal flag in zero phase", 0, int'(vec_monitor[0]));
      wait_sw_change(n, low);  // closes for the next signal phase
      check_val("signal flag in signal phase", 1, int'(vec_monitor[0]));
      check_val("zero flag in signal phase", 0, int'(vec_monitor[1]));
      check_val("cycle count", (sw_rises - 1) % CYC_MOD, int'(vec_monitor[6:2]));
    end
    report_test("monitor", err0);
  endtask

  // new durations right after a close while the current phase keeps its length
  task automatic test_duration_changes();
    int          err0;
    int          n;
    int          low;
    int          r;
    int          s_cur;
    logic [31:0] rnd;
    int          sig_vals[$];
    int          zero_vals[$];
    err0  = errors;
    s_cur = 4;  // left by the monitor test
    for (r = 0; r < 4; r++)
    begin
      rnd = $random(seed);
      sig_vals.push_back(int'(rnd[3:0]));
      rnd = $random(seed);
      zero_vals.push_back(int'(rnd[3:0]));
    end
    sig_vals.push_back(0);  // below the floor including zero
    zero_vals.push_back(0);
    sig_vals.push_back(3);
    zero_vals.push_back(1);
    sig_vals.push_back(5);
    zero_vals.push_back(5);
    for (r = 0; r < sig_vals.size(); r++)
    begin
      set_durations(sig_vals[r], zero_vals[r]);  // mid signal phase
      wait_sw_change(n, low);
      check_val("signal phase keeps sampled length", phase_len(s_cur), n);
      wait_sw_change(n, low);
      check_val("zero phase takes new length", phase_len(zero_vals[r]), n);
      s_cur = sig_vals[r];
    end
    report_test("duration changes", err0);
  endtask

  initial
  begin
    errors     = 0;
    checks     = 0;
    sw_rises   = 0;
    seed       = 32'h1f33;
    reset_dur  <= dur_t'(6);
    settle_dur <= dur_t'(9);
    test_reset();
    test_phase_lengths();
    test_break_before_make();
    test_monitor();
    test_duration_changes();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // stops a run that stalls
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/az_pkg.sv
logic/az_ctrl_if.sv
logic/phase_timer.sv
logic/az_sequencer.sv
logic/switch_driver.sv
logic/az_modulator.sv
verification/tb_clock.sv
verification/az_modulator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the output for a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module az_modulator_tb -o az_sim \
  && ./obj_dir/az_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
